// ==== rtl/mpu_bus_pkg.sv ====
`default_nettype none

package mpu_bus_pkg;

	// ==================================================================
	// host bus widths
	// ==================================================================
	localparam int ADDR_W    = 32;
	localparam int DATA_W    = 32;
	localparam int SEL_W     = DATA_W / 8;	// one enable per byte lane
	localparam int REG_ADR_W = 6;	// 64 bytes of registers per peripheral
	localparam int PAGE_W    = 24;	// upper address bits that pick a page

	typedef logic [ADDR_W-1:0]    addr_t;
	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [SEL_W-1:0]     sel_t;
	typedef logic [REG_ADR_W-1:0] reg_adr_t;
	typedef logic [PAGE_W-1:0]    page_t;

	// address map, everything else is external memory
	localparam page_t PIT_PAGE = 24'hFFDC11;
	localparam page_t PIC_PAGE = 24'hFFDC0F;

	// bus cycle controller states
	typedef enum logic [2:0] {
		IDLE     = 3'd0,	// waiting for req_i
		DECODE   = 3'd1,	// page compare on the held address
		REG_WAIT = 3'd2,	// stb sent, waiting for peripheral ack
		MEM_REQ  = 3'd3,	// memory request phase
		MEM_REL  = 3'd4,	// waiting for mem_ack_i to fall
		DONE     = 3'd5	// ack_o high until req_i drops
	} bus_state_e;

	// merge new bytes over an old word where the lane is enabled
	function automatic data_t apply_sel(input data_t old_w, input data_t new_w, input sel_t sel);
		data_t res;
		res = old_w;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		end
		return res;
	endfunction

endpackage

`default_nettype wire

// ==== rtl/mpu_irq_pkg.sv ====
`default_nettype none

package mpu_irq_pkg;

	// ==================================================================
	// interrupt sources
	// ==================================================================
	localparam int MAX_SOURCES = 32;	// ext lines plus timer channels
	localparam int CAUSE_W     = $clog2(MAX_SOURCES);

	typedef logic [CAUSE_W-1:0] irq_cause_t;

	// interrupt controller register offsets
	localparam logic [5:0] PIC_PEND_OFS  = 6'h00;	// pending, write 1 to clear
	localparam logic [5:0] PIC_EN_OFS    = 6'h04;	// enable mask
	localparam logic [5:0] PIC_CAUSE_OFS = 6'h08;	// current cause, read only

	// ==================================================================
	// timer control word
	// ==================================================================
	localparam int TCTL_EN_BIT   = 0;	// channel counts while set
	localparam int TCTL_AUTO_BIT = 1;	// reload at zero instead of stopping

endpackage

`default_nettype wire

// ==== rtl/mpu_reg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// single-beat register port, controller to one peripheral
interface mpu_reg_if;
	import mpu_bus_pkg::*;

	logic     stb;	// one cycle strobe
	logic     we;
	sel_t     sel;
	reg_adr_t adr;	// offset inside the page
	data_t    wdata;
	data_t    rdata;	// valid with ack
	logic     ack;	// one cycle, next edge after stb

	modport master (
		output stb, we, sel, adr, wdata,
		input  rdata, ack
	);

	modport slave (
		input  stb, we, sel, adr, wdata,
		output rdata, ack
	);

endinterface

`default_nettype wire

// ==== rtl/mpu_bus_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mpu_bus_ctrl (
	input  logic               clk_i,
	input  logic               arst_n_i,
	// host port, four-phase req/ack
	input  logic               req_i,
	input  logic               we_i,
	input  mpu_bus_pkg::addr_t adr_i,
	input  mpu_bus_pkg::sel_t  sel_i,
	input  mpu_bus_pkg::data_t wdata_i,
	output logic               ack_o,
	output mpu_bus_pkg::data_t rdata_o,
	// external memory port, same handshake
	output logic               mem_req_o,
	output logic               mem_we_o,
	output mpu_bus_pkg::addr_t mem_adr_o,
	output mpu_bus_pkg::sel_t  mem_sel_o,
	output mpu_bus_pkg::data_t mem_wdata_o,
	input  logic               mem_ack_i,
	input  mpu_bus_pkg::data_t mem_rdata_i,
	// on-chip peripherals
	mpu_reg_if.master          pit_bus,
	mpu_reg_if.master          pic_bus
);
	import mpu_bus_pkg::*;

	bus_state_e state_q;
	addr_t      adr_q;	// held request
	logic       we_q;
	sel_t       sel_q;
	data_t      wdata_q;
	data_t      rdata_q;	// word returned to the host
	logic       hit_pit_q;	// steers rdata and ack in REG_WAIT
	page_t      page;
	logic       reg_ack;

	assign page    = adr_q[ADDR_W-1 -: PAGE_W];
	assign reg_ack = hit_pit_q ? pit_bus.ack : pic_bus.ack;

	// both register ports see the same held request, only stb differs
	assign pit_bus.we    = we_q;
	assign pit_bus.sel   = sel_q;
	assign pit_bus.adr   = adr_q[REG_ADR_W-1:0];
	assign pit_bus.wdata = wdata_q;
	assign pic_bus.we    = we_q;
	assign pic_bus.sel   = sel_q;
	assign pic_bus.adr   = adr_q[REG_ADR_W-1:0];
	assign pic_bus.wdata = wdata_q;

	// memory side is held steady for the whole cycle
	assign mem_we_o    = we_q;
	assign mem_adr_o   = adr_q;
	assign mem_sel_o   = sel_q;
	assign mem_wdata_o = wdata_q;
	assign rdata_o     = rdata_q;

	// latch request when a new cycle starts
	always_ff @(posedge clk_i) begin
		if (state_q == IDLE && req_i) begin
			adr_q   <= adr_i;
			we_q    <= we_i;
			sel_q   <= sel_i;
			wdata_q <= wdata_i;
		end
	end

	// returning word, from a peripheral or from memory
	always_ff @(posedge clk_i) begin
		if (state_q == REG_WAIT && reg_ack) begin
			rdata_q <= hit_pit_q ? pit_bus.rdata : pic_bus.rdata;
		end else if (state_q == MEM_REQ && mem_req_o && mem_ack_i) begin
			rdata_q <= mem_rdata_i;
		end
	end

	// ==================================================================
	// cycle state machine
	// ==================================================================
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q     <= IDLE;
			ack_o       <= 1'b0;
			mem_req_o   <= 1'b0;
			hit_pit_q   <= 1'b0;
			pit_bus.stb <= 1'b0;
			pic_bus.stb <= 1'b0;
		end else begin
			pit_bus.stb <= 1'b0;	// strobes are single cycle
			pic_bus.stb <= 1'b0;
			case (state_q)
				IDLE: begin
					if (req_i)
						state_q <= DECODE;
				end
				DECODE: begin
					hit_pit_q <= (page == PIT_PAGE);
					if (page == PIT_PAGE) begin
						pit_bus.stb <= 1'b1;
						state_q     <= REG_WAIT;
					end else if (page == PIC_PAGE) begin
						pic_bus.stb <= 1'b1;
						state_q     <= REG_WAIT;
					end else begin
						state_q <= MEM_REQ;	// miss on both pages
					end
				end
				REG_WAIT: begin
					if (reg_ack) begin
						ack_o   <= 1'b1;	// 3rd edge after req sampled
						state_q <= DONE;
					end
				end
				MEM_REQ: begin
					if (!mem_req_o) begin
						mem_req_o <= 1'b1;	// first cycle in this state
					end else if (mem_ack_i) begin
						mem_req_o <= 1'b0;	// data taken, release
						state_q   <= MEM_REL;
					end
				end
				MEM_REL: begin
					// memory must finish its handshake first
					if (!mem_ack_i) begin
						ack_o   <= 1'b1;
						state_q <= DONE;
					end
				end
				DONE: begin
					if (!req_i) begin
						ack_o   <= 1'b0;
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/mpu_pit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mpu_pit #(
	parameter int N_TIMERS = 3	// at most 4, 16 bytes per channel
) (
	input  logic                clk_i,
	input  logic                arst_n_i,
	mpu_reg_if.slave            bus,
	output logic [N_TIMERS-1:0] tmr_out_o
);
	import mpu_bus_pkg::*;
	import mpu_irq_pkg::*;

	// per channel state
	data_t               reload_q [N_TIMERS];
	data_t               cnt_q    [N_TIMERS];
	logic [N_TIMERS-1:0] en_q;
	logic [N_TIMERS-1:0] auto_q;
	logic [N_TIMERS-1:0] out_q;

	logic [1:0] acc_ch;	// channel field of the offset
	logic [1:0] acc_reg;	// 0 reload, 1 count, 2 control
	logic       wr;
	data_t      rd_word;

	assign acc_ch    = bus.adr[5:4];
	assign acc_reg   = bus.adr[3:2];
	assign wr        = bus.stb && bus.we;
	assign tmr_out_o = out_q;

	// ==================================================================
	// counters and register writes
	// ==================================================================
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			en_q   <= '0;
			auto_q <= '0;
			out_q  <= '0;
			for (int t = 0; t < N_TIMERS; t++) begin
				reload_q[t] <= '0;
				cnt_q[t]    <= '0;
			end
		end else begin
			for (int t = 0; t < N_TIMERS; t++) begin
				out_q[t] <= 1'b0;
				if (en_q[t]) begin
					if (cnt_q[t] == '0) begin
						out_q[t] <= 1'b1;	// one cycle pulse at terminal count
						if (auto_q[t])
							cnt_q[t] <= reload_q[t];	// period R+1
						else
							en_q[t] <= 1'b0;	// one-shot, stop here
					end else begin
						cnt_q[t] <= cnt_q[t] - 1'b1;
					end
				end
				// host write wins over the count update
				if (wr && acc_ch == t) begin
					case (acc_reg)
						2'd0: begin
							reload_q[t] <= apply_sel(reload_q[t], bus.wdata, bus.sel);
							cnt_q[t]    <= apply_sel(reload_q[t], bus.wdata, bus.sel);
						end
						2'd2: begin
							if (bus.sel[0]) begin
								en_q[t]   <= bus.wdata[TCTL_EN_BIT];
								auto_q[t] <= bus.wdata[TCTL_AUTO_BIT];
							end
						end
						default: ;	// count is read only
					endcase
				end
			end
		end
	end

	// read mux, anything unmapped reads zero
	always_comb begin
		rd_word = '0;
		for (int t = 0; t < N_TIMERS; t++) begin
			if (acc_ch == t) begin
				case (acc_reg)
					2'd0: rd_word = reload_q[t];
					2'd1: rd_word = cnt_q[t];
					2'd2: begin
						rd_word[TCTL_EN_BIT]   = en_q[t];
						rd_word[TCTL_AUTO_BIT] = auto_q[t];
					end
					default: rd_word = '0;
				endcase
			end
		end
	end

	// ==================================================================
	// register port response
	// ==================================================================
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			bus.ack <= 1'b0;
		else
			bus.ack <= bus.stb;	// answer on the next edge
	end

	always_ff @(posedge clk_i) begin
		if (bus.stb)
			bus.rdata <= rd_word;	// valid together with ack
	end

endmodule

`default_nettype wire

// ==== rtl/mpu_pic.sv ====
`timescale 1ns/1ps
`default_nettype none

module mpu_pic #(
	parameter int N_EXT_IRQ = 8,
	parameter int N_TIMERS  = 3
) (
	input  logic                   clk_i,
	input  logic                   arst_n_i,
	mpu_reg_if.slave               bus,
	input  logic [N_EXT_IRQ-1:0]   irq_i,	// asynchronous external lines
	input  logic [N_TIMERS-1:0]    tmr_i,	// timer pulses, already on clk_i
	output logic                   irq_o,
	output mpu_irq_pkg::irq_cause_t cause_o
);
	import mpu_bus_pkg::*;
	import mpu_irq_pkg::*;

	localparam int N_SRC = N_EXT_IRQ + N_TIMERS;	// timers sit above ext lines

	logic [N_EXT_IRQ-1:0]   ext_s1, ext_s2;	// two-flop synchronizer
	logic [N_SRC-1:0]       src, src_d, rise;
	logic [N_SRC-1:0]       pend_q, en_q, act, clr;
	logic [MAX_SOURCES-1:0] pend_w, en_w;	// zero padded for readback
	logic                   irq_q;
	irq_cause_t             cause_q, first;
	logic                   wr;
	data_t                  wr_word, en_word, rd_word;

	assign src    = {tmr_i, ext_s2};
	assign rise   = src & ~src_d;
	assign act    = pend_q & en_q;
	assign wr     = bus.stb && bus.we;
	assign pend_w = MAX_SOURCES'(pend_q);
	assign en_w   = MAX_SOURCES'(en_q);

	// ==================================================================
	// write data shaping
	// ==================================================================
	always_comb begin
		wr_word = apply_sel('0, bus.wdata, bus.sel);	// lanes not written clear nothing
		en_word = apply_sel(data_t'(en_q), bus.wdata, bus.sel);
		clr     = (wr && bus.adr == PIC_PEND_OFS) ? wr_word[N_SRC-1:0] : '0;
	end

	// lowest index wins
	always_comb begin
		first = '0;
		for (int i = N_SRC - 1; i >= 0; i--) begin
			if (act[i])
				first = irq_cause_t'(i);
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ext_s1  <= '0;
			ext_s2  <= '0;
			src_d   <= '0;
			pend_q  <= '0;
			en_q    <= '0;
			irq_q   <= 1'b0;
			cause_q <= '0;
		end else begin
			ext_s1 <= irq_i;
			ext_s2 <= ext_s1;
			src_d  <= src;	// edge flop
			// a new edge in the clearing cycle stays pending
			pend_q <= (pend_q & ~clr) | rise;
			if (wr && bus.adr == PIC_EN_OFS)
				en_q <= en_word[N_SRC-1:0];
			irq_q   <= |act;	// one cycle behind pending/enable
			cause_q <= first;
		end
	end

	assign irq_o   = irq_q;
	assign cause_o = cause_q;

	// ==================================================================
	// register readback
	// ==================================================================
	always_comb begin
		case (bus.adr)
			PIC_PEND_OFS:  rd_word = pend_w;
			PIC_EN_OFS:    rd_word = en_w;
			PIC_CAUSE_OFS: rd_word = data_t'(cause_q);
			default:       rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			bus.ack <= 1'b0;
		else
			bus.ack <= bus.stb;
	end

	always_ff @(posedge clk_i) begin
		if (bus.stb)
			bus.rdata <= rd_word;
	end

endmodule

`default_nettype wire

// ==== rtl/mpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mpu_top #(
	parameter int N_EXT_IRQ = 8,	// ext lines + timers must fit in 32 sources
	parameter int N_TIMERS  = 3
) (
	input  logic                    clk_i,
	input  logic                    arst_n_i,
	// host port
	input  logic                    req_i,
	input  logic                    we_i,
	input  mpu_bus_pkg::addr_t      adr_i,
	input  mpu_bus_pkg::sel_t       sel_i,
	input  mpu_bus_pkg::data_t      wdata_i,
	output logic                    ack_o,
	output mpu_bus_pkg::data_t      rdata_o,
	// memory port
	output logic                    mem_req_o,
	output logic                    mem_we_o,
	output mpu_bus_pkg::addr_t      mem_adr_o,
	output mpu_bus_pkg::sel_t       mem_sel_o,
	output mpu_bus_pkg::data_t      mem_wdata_o,
	input  logic                    mem_ack_i,
	input  mpu_bus_pkg::data_t      mem_rdata_i,
	// interrupts
	input  logic [N_EXT_IRQ-1:0]    irq_i,
	output logic                    irq_o,
	output mpu_irq_pkg::irq_cause_t cause_o
);

	logic [N_TIMERS-1:0] tmr_out;	// timer pulses into the pic

	mpu_reg_if pit_bus ();
	mpu_reg_if pic_bus ();

	mpu_bus_ctrl u_bus_ctrl (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.req_i       (req_i),
		.we_i        (we_i),
		.adr_i       (adr_i),
		.sel_i       (sel_i),
		.wdata_i     (wdata_i),
		.ack_o       (ack_o),
		.rdata_o     (rdata_o),
		.mem_req_o   (mem_req_o),
		.mem_we_o    (mem_we_o),
		.mem_adr_o   (mem_adr_o),
		.mem_sel_o   (mem_sel_o),
		.mem_wdata_o (mem_wdata_o),
		.mem_ack_i   (mem_ack_i),
		.mem_rdata_i (mem_rdata_i),
		.pit_bus     (pit_bus),
		.pic_bus     (pic_bus)
	);

	mpu_pit #(.N_TIMERS(N_TIMERS)) u_pit (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.bus       (pit_bus),
		.tmr_out_o (tmr_out)
	);

	// timer channel t shows up as source N_EXT_IRQ+t
	mpu_pic #(.N_EXT_IRQ(N_EXT_IRQ), .N_TIMERS(N_TIMERS)) u_pic (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.bus      (pic_bus),
		.irq_i    (irq_i),
		.tmr_i    (tmr_out),
		.irq_o    (irq_o),
		.cause_o  (cause_o)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_mpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mpu_top;
	import mpu_bus_pkg::*;
	import mpu_irq_pkg::*;

	localparam int    N_EXT    = 8;
	localparam int    N_TMR    = 3;
	localparam int    LIMIT    = 200;	// cycles allowed for any single wait
	localparam addr_t PIT_BASE = {PIT_PAGE, 8'h00};
	localparam addr_t PIC_BASE = {PIC_PAGE, 8'h00};
	localparam data_t CTL_EN   = 32'(1) << TCTL_EN_BIT;
	localparam data_t CTL_AUTO = 32'(1) << TCTL_AUTO_BIT;

	logic             clk_i = 1'b0;
	logic             arst_n_i, req_i, we_i, ack_o;
	addr_t            adr_i, mem_adr_o;
	sel_t             sel_i, mem_sel_o;
	data_t            wdata_i, rdata_o, mem_wdata_o, mem_rdata_i;
	logic             mem_req_o, mem_we_o, mem_ack_i;
	logic [N_EXT-1:0] irq_i;
	logic             irq_o;
	irq_cause_t       cause_o;

	data_t  mem_words [256];	// word model, indexed by adr[9:2]
	addr_t  seen_adr;	// last memory request as the responder saw it
	sel_t   seen_sel;
	data_t  seen_wdata;
	logic   seen_we;
	integer seed = 94;
	int     checks, errors, tests, last_lat;

	mpu_top #(.N_EXT_IRQ(N_EXT), .N_TIMERS(N_TMR)) u_mpu_top (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.req_i(req_i), .we_i(we_i), .adr_i(adr_i), .sel_i(sel_i), .wdata_i(wdata_i),
		.ack_o(ack_o), .rdata_o(rdata_o),
		.mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_adr_o(mem_adr_o),
		.mem_sel_o(mem_sel_o), .mem_wdata_o(mem_wdata_o),
		.mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i),
		.irq_i(irq_i), .irq_o(irq_o), .cause_o(cause_o)
	);

	always #50 clk_i = ~clk_i;	// 100 ns period

	// ==================================================================
	// compare tasks and bookkeeping
	// ==================================================================
	task automatic check_data(input string name, input data_t got, input data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_cause(input string name, input irq_cause_t got, input irq_cause_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, got);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, got);
		end
	endtask

	task automatic halt_on_timeout(input string what);
		$display("timeout at %0t: no sign of %s", $time, what);
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors + 1);
		$display("** FAIL **");
		$finish;
	endtask

	task automatic end_test(input string name, input int e0);
		tests++;
		if (errors == e0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d mismatches", name, errors - e0);
	endtask

	function automatic data_t fill_word(input int idx);
		return 32'hA5C3_0000 ^ data_t'(idx << 2);	// byte address folded in
	endfunction

	// ==================================================================
	// host side, four-phase cycle
	// ==================================================================
	task automatic bus_cycle(input logic we, input addr_t adr, input sel_t sel,
		input data_t wdata, output data_t rdata);
		int n;
		@(posedge clk_i);
		req_i   <= 1'b1;
		we_i    <= we;
		adr_i   <= adr;
		sel_i   <= sel;
		wdata_i <= wdata;
		@(posedge clk_i);	// first edge that samples req_i
		n = 0;
		@(negedge clk_i);
		while (!ack_o) begin
			if (n == LIMIT)
				halt_on_timeout("ack_o rising");
			@(negedge clk_i);
			n++;
		end
		rdata    = rdata_o;
		last_lat = n;	// edges after the sampling edge
		@(posedge clk_i);
		req_i <= 1'b0;
		n = 0;
		@(negedge clk_i);
		while (ack_o) begin
			if (n == LIMIT)
				halt_on_timeout("ack_o falling");
			@(negedge clk_i);
			n++;
		end
	endtask

	task automatic bus_write(input addr_t adr, input sel_t sel, input data_t wdata);
		data_t unused;
		bus_cycle(1'b1, adr, sel, wdata, unused);
	endtask

	task automatic bus_read(input addr_t adr, output data_t rdata);
		bus_cycle(1'b0, adr, 4'hF, '0, rdata);
	endtask

	task automatic expect_read(input addr_t adr, input data_t exp, input string name);
		data_t rd;
		bus_read(adr, rd);
		check_data(name, rd, exp);
	endtask

	task automatic wait_irq(input logic level);
		int n;
		n = 0;
		@(negedge clk_i);
		while (irq_o !== level) begin
			if (n == LIMIT)
				halt_on_timeout("irq_o changing");
			@(negedge clk_i);
			n++;
		end
	endtask

	// memory responder, random latency per request
	always begin : mem_responder
		int dly;
		int idx;
		int n;
		@(negedge clk_i);
		if (mem_req_o && !mem_ack_i) begin
			seen_adr   = mem_adr_o;
			seen_sel   = mem_sel_o;
			seen_wdata = mem_wdata_o;
			seen_we    = mem_we_o;
			idx        = int'(mem_adr_o[9:2]);
			dly        = $random(seed) & 7;	// 0 to 7 cycles
			repeat (dly) @(posedge clk_i);
			@(posedge clk_i);
			if (seen_we) begin
				for (int b = 0; b < 4; b++) begin
					if (seen_sel[b])
						mem_words[idx][8*b +: 8] = seen_wdata[8*b +: 8];
				end
			end
			mem_rdata_i <= mem_words[idx];
			mem_ack_i   <= 1'b1;
			n = 0;
			@(negedge clk_i);
			while (mem_req_o) begin
				if (n == LIMIT)
					halt_on_timeout("mem_req_o falling");
				@(negedge clk_i);
				n++;
			end
			@(posedge clk_i);
			mem_ack_i <= 1'b0;
		end
	end

	// ==================================================================
	// tests
	// ==================================================================
	task automatic test_reset_state();
		int    e0;
		data_t rd;
		e0 = errors;
		check_bit("ack_o", ack_o, 1'b0);
		check_bit("mem_req_o", mem_req_o, 1'b0);
		check_bit("irq_o", irq_o, 1'b0);
		bus_read(PIC_BASE, rd);
		check_data("pending register", rd, '0);
		check_data("ack_o latency", data_t'(last_lat), 32'd3);
		expect_read(PIC_BASE + 4, '0, "enable register");
		expect_read(PIT_BASE + 8, '0, "channel 0 control");
		end_test("reset state", e0);
	endtask

	task automatic test_reg_access();
		int e0;
		e0 = errors;
		bus_write(PIC_BASE + 4, 4'hF, 32'h0000_0123);
		expect_read(PIC_BASE + 4, 32'h0000_0123, "enable register");
		bus_write(PIC_BASE + 4, 4'hF, '0);
		bus_write(PIT_BASE, 4'hF, 32'h0000_BEEF);
		expect_read(PIT_BASE, 32'h0000_BEEF, "channel 0 reload");
		expect_read(PIT_BASE + 4, 32'h0000_BEEF, "channel 0 count");	// loaded by reload
		bus_write(PIT_BASE, 4'b0010, 32'h1234_7756);	// only lane 1 lands
		expect_read(PIT_BASE, 32'h0000_77EF, "channel 0 reload lane 1");
		expect_read(PIT_BASE + 12, '0, "unused offset 0x0c");
		expect_read(PIT_BASE + 48, '0, "unused offset 0x30");	// no channel 3
		end_test("register access", e0);
	endtask

	task automatic test_mem_pass();
		int    e0;
		addr_t a;
		e0 = errors;
		bus_write(32'h0000_0040, 4'hF, 32'h1122_3344);
		check_data("mem_adr_o", seen_adr, 32'h0000_0040);
		check_data("mem_sel_o", data_t'(seen_sel), 32'hF);
		check_data("mem_wdata_o", seen_wdata, 32'h1122_3344);
		check_bit("mem_we_o", seen_we, 1'b1);
		bus_write(32'h0000_0040, 4'b0101, 32'hAABB_CCDD);
		check_data("mem_sel_o", data_t'(seen_sel), 32'h5);
		expect_read(32'h0000_0040, 32'h11BB_33DD, "rdata_o merged word");
		check_bit("mem_we_o", seen_we, 1'b0);
		// just below the timer page, still memory
		bus_write(32'hFFDC_1004, 4'hF, 32'hCAFE_F00D);
		check_data("mem_adr_o", seen_adr, 32'hFFDC_1004);
		expect_read(32'hFFDC_1004, 32'hCAFE_F00D, "rdata_o near page");
		expect_read(32'h0000_0104, fill_word(32'h104 >> 2), "rdata_o untouched word");
		for (int k = 0; k < 6; k++) begin
			a = 32'h2000_0200 + addr_t'(k * 4);
			bus_write(a, 4'hF, 32'h0F0F_0000 + data_t'(k * 7));
			check_data("mem_adr_o", seen_adr, a);
		end
		for (int k = 0; k < 6; k++)
			expect_read(32'h2000_0200 + addr_t'(k * 4), 32'h0F0F_0000 + data_t'(k * 7),
				"rdata_o word run");
		end_test("memory pass-through", e0);
	endtask

	task automatic test_timer_irq();
		int e0;
		e0 = errors;
		bus_write(PIC_BASE + 4, 4'hF, 32'(1) << (N_EXT + 1));	// channel 1 source
		bus_write(PIT_BASE + 16, 4'hF, 32'd4);
		bus_write(PIT_BASE + 24, 4'hF, CTL_EN | CTL_AUTO);
		wait_irq(1'b1);
		check_cause("cause_o", cause_o, irq_cause_t'(N_EXT + 1));
		expect_read(PIC_BASE + 8, 32'(N_EXT + 1), "cause register");
		bus_write(PIT_BASE + 24, 4'hF, '0);	// stop it so nothing re-pends
		bus_write(PIC_BASE, 4'hF, 32'(1) << (N_EXT + 1));
		wait_irq(1'b0);
		expect_read(PIC_BASE, '0, "pending register");
		// channel 2 as one-shot
		bus_write(PIC_BASE + 4, 4'hF, 32'(1) << (N_EXT + 2));
		bus_write(PIT_BASE + 32, 4'hF, 32'd3);
		bus_write(PIT_BASE + 40, 4'hF, CTL_EN);
		wait_irq(1'b1);
		check_cause("cause_o", cause_o, irq_cause_t'(N_EXT + 2));
		expect_read(PIT_BASE + 40, '0, "channel 2 control");	// enable dropped
		bus_write(PIC_BASE, 4'hF, 32'(1) << (N_EXT + 2));
		wait_irq(1'b0);
		bus_write(PIC_BASE + 4, 4'hF, '0);
		end_test("timer interrupt", e0);
	endtask

	task automatic test_ext_priority();
		int e0;
		e0 = errors;
		bus_write(PIC_BASE + 4, 4'hF, 32'h24);
		@(posedge clk_i);
		irq_i <= 8'h24;	// lines 2 and 5 together
		wait_irq(1'b1);
		expect_read(PIC_BASE, 32'h24, "pending register");
		check_cause("cause_o", cause_o, irq_cause_t'(2));
		expect_read(PIC_BASE + 8, 32'd2, "cause register");
		bus_write(PIC_BASE, 4'hF, 32'h4);
		check_bit("irq_o", irq_o, 1'b1);
		check_cause("cause_o", cause_o, irq_cause_t'(5));
		expect_read(PIC_BASE + 8, 32'd5, "cause register");
		bus_write(PIC_BASE, 4'hF, 32'h20);
		wait_irq(1'b0);
		@(posedge clk_i);
		irq_i <= '0;
		bus_write(PIC_BASE + 4, 4'hF, '0);
		end_test("external priority", e0);
	endtask

	task automatic test_masking();
		int    e0;
		int    n;
		data_t rd;
		e0 = errors;
		@(posedge clk_i);
		irq_i <= 8'h80;	// line 7, mask still clear
		n  = 0;
		rd = '0;
		while (!rd[7]) begin
			if (n == LIMIT)
				halt_on_timeout("pending bit 7");
			bus_read(PIC_BASE, rd);
			n++;
		end
		check_bit("irq_o while masked", irq_o, 1'b0);
		bus_write(PIC_BASE + 4, 4'hF, 32'h80);
		wait_irq(1'b1);
		check_cause("cause_o", cause_o, irq_cause_t'(7));
		bus_write(PIC_BASE, 4'hF, 32'h80);
		wait_irq(1'b0);
		@(posedge clk_i);
		irq_i <= '0;
		end_test("masking", e0);
	endtask

	initial begin
		arst_n_i    <= 1'b0;
		req_i       <= 1'b0;
		we_i        <= 1'b0;
		adr_i       <= '0;
		sel_i       <= '0;
		wdata_i     <= '0;
		mem_ack_i   <= 1'b0;
		mem_rdata_i <= '0;
		irq_i       <= '0;
		for (int i = 0; i < 256; i++)
			mem_words[i] = fill_word(i);
		repeat (10) @(posedge clk_i);
		arst_n_i <= 1'b1;
		test_reset_state();
		test_reg_access();
		test_mem_pass();
		test_timer_irq();
		test_ext_priority();
		test_masking();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/mpu_bus_pkg.sv
rtl/mpu_irq_pkg.sv
rtl/mpu_reg_if.sv
rtl/mpu_bus_ctrl.sv
rtl/mpu_pit.sv
rtl/mpu_pic.sv
rtl/mpu_top.sv
testbench/tb_mpu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_mpu_top -f tb.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qF "** FAIL **" sim.log; then
	echo "simulation reported errors"
	exit 1
fi
if ! grep -qF "** PASS **" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
